// ==== mdu_pkg.sv ====
package mdu_pkg;

	typedef logic [31:0] word_t;

	// one-hot operation, all zero means idle
	typedef logic [8:0] mdu_op_t;

	localparam int OP_MULT  = 0;
	localparam int OP_MULTU = 1;
	localparam int OP_DIV   = 2;
	localparam int OP_DIVU  = 3;
	localparam int OP_MFHI  = 4;
	localparam int OP_MFLO  = 5;
	localparam int OP_MTHI  = 6;
	localparam int OP_MTLO  = 7;
	localparam int OP_MUL   = 8;

	// stage 1 to stage 2 payload
	typedef struct packed {
		logic    valid;
		mdu_op_t op;
		// partial products of the magnitudes, a:b by c:d halves
		word_t   ac;
		word_t   ad;
		word_t   cb;
		word_t   bd;
		logic    res_neg;
		word_t   opr1;
		word_t   opr2;
	} mdu_s1_t;

	// writeback towards HI/LO and the register file
	typedef struct packed {
		logic  hi_wen;
		logic  lo_wen;
		word_t hi;
		word_t lo;
		logic  mfhi;
		logic  mflo;
		logic  mul;
	} mdu_wb_t;

	typedef struct packed {
		word_t dividend;
		word_t divisor;
		logic  is_signed;
	} div_req_t;

	typedef struct packed {
		word_t quot;
		word_t rem;
	} div_rsp_t;

endpackage

// ==== mdu_s1.sv ====
`timescale 1ns/1ps

module mdu_s1 (
	input  logic              clk,
	input  logic              rst_n_i,
	input  mdu_pkg::mdu_op_t  op_i,
	input  mdu_pkg::word_t    opr1_i,
	input  mdu_pkg::word_t    opr2_i,
	input  logic              stall_i,
	input  logic              flush_i,
	output mdu_pkg::mdu_s1_t  s1_o
);
	import mdu_pkg::*;

	logic    is_signed;
	logic    neg1;
	logic    neg2;
	word_t   mag1;
	word_t   mag2;

	logic    valid_q;
	mdu_op_t op_q;
	word_t   ac_q;
	word_t   ad_q;
	word_t   cb_q;
	word_t   bd_q;
	logic    neg_q;
	word_t   opr1_q;
	word_t   opr2_q;

	assign is_signed = op_i[OP_MULT] | op_i[OP_DIV] | op_i[OP_MUL];
	assign neg1      = is_signed & opr1_i[31];
	assign neg2      = is_signed & opr2_i[31];

	// 0x80000000 negates to itself, which is the right unsigned magnitude
	assign mag1 = neg1 ? -opr1_i : opr1_i;
	assign mag2 = neg2 ? -opr2_i : opr2_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			op_q    <= '0;
		end else if (flush_i) begin
			valid_q <= 1'b0;
		end else if (!stall_i) begin
			valid_q <= |op_i;
			op_q    <= op_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ac_q   <= {16'd0, mag1[31:16]} * {16'd0, mag2[31:16]};
			ad_q   <= {16'd0, mag1[31:16]} * {16'd0, mag2[15:0]};
			cb_q   <= {16'd0, mag1[15:0]} * {16'd0, mag2[31:16]};
			bd_q   <= {16'd0, mag1[15:0]} * {16'd0, mag2[15:0]};
			neg_q  <= neg1 ^ neg2;
			opr1_q <= opr1_i;
			opr2_q <= opr2_i;
		end
	end

	assign s1_o.valid   = valid_q;
	assign s1_o.op      = op_q;
	assign s1_o.ac      = ac_q;
	assign s1_o.ad      = ad_q;
	assign s1_o.cb      = cb_q;
	assign s1_o.bd      = bd_q;
	assign s1_o.res_neg = neg_q;
	assign s1_o.opr1    = opr1_q;
	assign s1_o.opr2    = opr2_q;

endmodule

// ==== mdu_s2.sv ====
`timescale 1ns/1ps

module mdu_s2 (
	input  logic              clk,
	input  logic              rst_n_i,
	input  mdu_pkg::mdu_s1_t  s1_i,
	input  logic              stall_i,
	input  logic              flush_i,
	input  mdu_pkg::word_t    hi_i,
	input  mdu_pkg::word_t    lo_i,
	output mdu_pkg::div_req_t div_req_o,
	output logic              div_start_o,
	input  logic              div_done_i,
	input  logic              div_busy_i,
	input  mdu_pkg::div_rsp_t div_rsp_i,
	output mdu_pkg::mdu_wb_t  wb_o,
	output logic              stall_req_o,
	output logic              busy_o,
	output logic              div_busy_o
);
	import mdu_pkg::*;

	logic [63:0] sum;
	logic [63:0] prod;
	logic        is_div_in;
	word_t       hi_nxt;
	word_t       lo_nxt;
	logic        div_end;
	logic        res_vld;

	logic        valid_q;
	mdu_op_t     op_q;
	logic        div_wait_q;
	logic        started_q;
	word_t       hi_q;
	word_t       lo_q;
	div_req_t    req_q;

	// shifted partial products, then the sign
	assign sum = {s1_i.ac, 32'd0}
		+ {16'd0, s1_i.ad, 16'd0}
		+ {16'd0, s1_i.cb, 16'd0}
		+ {32'd0, s1_i.bd};
	assign prod = s1_i.res_neg ? -sum : sum;

	assign is_div_in = s1_i.op[OP_DIV] | s1_i.op[OP_DIVU];
	assign hi_nxt    = s1_i.op[OP_MTHI] ? s1_i.opr1 : prod[63:32];
	assign lo_nxt    = s1_i.op[OP_MTLO] ? s1_i.opr1 : prod[31:0];

	// wait for a free divider before the single start pulse
	assign div_start_o = div_wait_q & ~started_q & ~div_busy_i;
	// a done is only ours once our start went out
	assign div_end     = div_wait_q & started_q & div_done_i;
	assign div_req_o   = req_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q    <= 1'b0;
			op_q       <= '0;
			div_wait_q <= 1'b0;
			started_q  <= 1'b0;
		end else if (flush_i) begin
			valid_q    <= 1'b0;
			div_wait_q <= 1'b0;
			started_q  <= 1'b0;
		end else if (div_wait_q) begin
			if (div_start_o)
				started_q <= 1'b1;
			if (div_end) begin
				div_wait_q <= 1'b0;
				started_q  <= 1'b0;
			end
		end else if (!stall_i) begin
			valid_q    <= s1_i.valid;
			op_q       <= s1_i.op;
			div_wait_q <= s1_i.valid & is_div_in;
		end
	end

	always_ff @(posedge clk) begin
		if (div_wait_q) begin
			if (div_end) begin
				hi_q <= div_rsp_i.rem;
				lo_q <= div_rsp_i.quot;
			end
		end else if (!stall_i) begin
			hi_q            <= hi_nxt;
			lo_q            <= lo_nxt;
			req_q.dividend  <= s1_i.opr1;
			req_q.divisor   <= s1_i.opr2;
			req_q.is_signed <= s1_i.op[OP_DIV];
		end
	end

	// result is visible only once a divide has finished
	assign res_vld = valid_q & ~div_wait_q;

	assign wb_o.hi_wen = res_vld & (op_q[OP_MULT] | op_q[OP_MULTU] | op_q[OP_DIV]
		| op_q[OP_DIVU] | op_q[OP_MTHI]);
	assign wb_o.lo_wen = res_vld & (op_q[OP_MULT] | op_q[OP_MULTU] | op_q[OP_DIV]
		| op_q[OP_DIVU] | op_q[OP_MTLO]);
	// MFHI/MFLO read the live registers so a move just before is seen
	assign wb_o.hi   = op_q[OP_MFHI] ? hi_i : hi_q;
	assign wb_o.lo   = op_q[OP_MFLO] ? lo_i : lo_q;
	assign wb_o.mfhi = res_vld & op_q[OP_MFHI];
	assign wb_o.mflo = res_vld & op_q[OP_MFLO];
	assign wb_o.mul  = res_vld & op_q[OP_MUL];

	assign stall_req_o = div_wait_q;
	assign busy_o      = valid_q;
	assign div_busy_o  = valid_q & (op_q[OP_DIV] | op_q[OP_DIVU]);

endmodule

// ==== mdu_div.sv ====
`timescale 1ns/1ps

module mdu_div (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              start_i,
	input  mdu_pkg::div_req_t req_i,
	output logic              busy_o,
	output logic              done_o,
	output mdu_pkg::div_rsp_t rsp_o
);
	import mdu_pkg::*;

	logic        accept;
	logic        dvd_neg;
	logic        dvs_neg;
	word_t       dvd_mag;
	word_t       dvs_mag;
	logic [64:0] shifted;
	logic [32:0] diff;
	logic [63:0] acc_nxt;

	logic        busy_q;
	logic        done_q;
	logic [4:0]  cnt_q;
	// remainder in the upper word, quotient shifts into the lower
	logic [63:0] acc_q;
	word_t       dvs_q;
	logic        qneg_q;
	logic        rneg_q;

	assign accept  = start_i & ~busy_q;
	assign dvd_neg = req_i.is_signed & req_i.dividend[31];
	assign dvs_neg = req_i.is_signed & req_i.divisor[31];
	assign dvd_mag = dvd_neg ? -req_i.dividend : req_i.dividend;
	assign dvs_mag = dvs_neg ? -req_i.divisor : req_i.divisor;

	// one restoring step
	assign shifted = {acc_q, 1'b0};
	assign diff    = shifted[64:32] - {1'b0, dvs_q};
	assign acc_nxt = diff[32] ? shifted[63:0] : {diff[31:0], shifted[31:1], 1'b1};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end else if (busy_q) begin
				cnt_q <= cnt_q + 5'd1;
				if (cnt_q == 5'd31) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			acc_q  <= {32'd0, dvd_mag};
			dvs_q  <= dvs_mag;
			qneg_q <= dvd_neg ^ dvs_neg;
			rneg_q <= dvd_neg;
		end else if (busy_q) begin
			acc_q <= acc_nxt;
		end
	end

	// zero divisor leaves |dividend| in the remainder already
	assign rsp_o.quot = (dvs_q == '0) ? '1 : (qneg_q ? -acc_q[31:0] : acc_q[31:0]);
	assign rsp_o.rem  = rneg_q ? -acc_q[63:32] : acc_q[63:32];

	assign busy_o = busy_q;
	assign done_o = done_q;

endmodule

// ==== mdu_hilo.sv ====
`timescale 1ns/1ps

module mdu_hilo (
	input  logic             clk,
	input  logic             rst_n_i,
	input  mdu_pkg::mdu_wb_t wb_i,
	output mdu_pkg::word_t   hi_o,
	output mdu_pkg::word_t   lo_o
);

	logic [31:0] hi_q;
	logic [31:0] lo_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			if (wb_i.hi_wen)
				hi_q <= wb_i.hi;
			if (wb_i.lo_wen)
				lo_q <= wb_i.lo;
		end
	end

	assign hi_o = hi_q;
	assign lo_o = lo_q;

endmodule

// ==== mdu_top.sv ====
`timescale 1ns/1ps

module mdu_top (
	input  logic             clk,
	input  logic             rst_n_i,
	input  mdu_pkg::mdu_op_t op_i,
	input  mdu_pkg::word_t   opr1_i,
	input  mdu_pkg::word_t   opr2_i,
	input  logic             s1_stall_i,
	input  logic             s1_flush_i,
	input  logic             s2_stall_i,
	input  logic             s2_flush_i,
	output mdu_pkg::mdu_wb_t wb_o,
	output logic             stall_req_o,
	output logic             busy_o,
	output logic             div_busy_o
);
	import mdu_pkg::*;

	mdu_s1_t  s1;
	div_req_t div_req;
	div_rsp_t div_rsp;
	logic     div_start;
	logic     div_done;
	logic     div_busy;
	word_t    hi;
	word_t    lo;

	mdu_s1 u_s1 (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.op_i    (op_i),
		.opr1_i  (opr1_i),
		.opr2_i  (opr2_i),
		.stall_i (s1_stall_i),
		.flush_i (s1_flush_i),
		.s1_o    (s1)
	);

	mdu_s2 u_s2 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.s1_i        (s1),
		.stall_i     (s2_stall_i),
		.flush_i     (s2_flush_i),
		.hi_i        (hi),
		.lo_i        (lo),
		.div_req_o   (div_req),
		.div_start_o (div_start),
		.div_done_i  (div_done),
		.div_busy_i  (div_busy),
		.div_rsp_i   (div_rsp),
		.wb_o        (wb_o),
		.stall_req_o (stall_req_o),
		.busy_o      (busy_o),
		.div_busy_o  (div_busy_o)
	);

	// shared by DIV and DIVU
	mdu_div u_div (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.start_i (div_start),
		.req_i   (div_req),
		.busy_o  (div_busy),
		.done_o  (div_done),
		.rsp_o   (div_rsp)
	);

	mdu_hilo u_hilo (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wb_i    (wb_o),
		.hi_o    (hi),
		.lo_o    (lo)
	);

endmodule

// ==== tb_mdu.sv ====
`timescale 1ns/1ps

module tb_mdu;
	import mdu_pkg::*;

	localparam int SEED        = 32'h06cf_6f6a;
	localparam int DIV_TIMEOUT = 100;

	logic    clk;
	logic    rst_n_i;
	mdu_op_t op_i;
	word_t   opr1_i;
	word_t   opr2_i;
	logic    s1_stall_i;
	logic    s1_flush_i;
	logic    s2_stall_i;
	logic    s2_flush_i;
	mdu_wb_t wb_o;
	logic    stall_req_o;
	logic    busy_o;
	logic    div_busy_o;
	int      errors;
	int      checks;

	mdu_top u_dut (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.op_i        (op_i),
		.opr1_i      (opr1_i),
		.opr2_i      (opr2_i),
		.s1_stall_i  (s1_stall_i),
		.s1_flush_i  (s1_flush_i),
		.s2_stall_i  (s2_stall_i),
		.s2_flush_i  (s2_flush_i),
		.wb_o        (wb_o),
		.stall_req_o (stall_req_o),
		.busy_o      (busy_o),
		.div_busy_o  (div_busy_o)
	);

	always #20 clk = ~clk;

	function automatic mdu_op_t op_of(input int bitn);
		return 9'd1 << bitn;
	endfunction

	function automatic logic [4:0] flags_of(input mdu_wb_t w);
		return {w.hi_wen, w.lo_wen, w.mfhi, w.mflo, w.mul};
	endfunction

	// reference product from plain 64-bit arithmetic
	function automatic logic [63:0] mul_ref(input word_t a, input word_t b, input logic sgn);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		sa = sgn ? {{32{a[31]}}, a} : {32'd0, a};
		sb = sgn ? {{32{b[31]}}, b} : {32'd0, b};
		return sa * sb;
	endfunction

	// {remainder, quotient}, truncating division
	function automatic logic [63:0] div_ref(input word_t a, input word_t b, input logic sgn);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] q;
		logic signed [63:0] r;
		if (b == '0)
			return {a, 32'hffff_ffff};
		sa = sgn ? {{32{a[31]}}, a} : {32'd0, a};
		sb = sgn ? {{32{b[31]}}, b} : {32'd0, b};
		q = sa / sb;
		r = sa % sb;
		return {r[31:0], q[31:0]};
	endfunction

	task automatic check_bits(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_idle();
		check_bits("wb_o enables and flags", 32'(flags_of(wb_o)), 32'd0);
	endtask

	task automatic check_wb(input mdu_wb_t want, input logic chk_hi, input logic chk_lo);
		check_bits("wb_o enables and flags", 32'(flags_of(wb_o)), 32'(flags_of(want)));
		if (chk_hi)
			check_bits("wb_o.hi", wb_o.hi, want.hi);
		if (chk_lo)
			check_bits("wb_o.lo", wb_o.lo, want.lo);
	endtask

	task automatic issue_op(input mdu_op_t op, input word_t a, input word_t b);
		@(posedge clk);
		op_i   <= op;
		opr1_i <= a;
		opr2_i <= b;
		@(posedge clk);
		op_i <= '0;
	endtask

	// nothing on wb_o one cycle after sampling, the result one cycle later
	task automatic run_op(input mdu_op_t op, input word_t a, input word_t b,
			input mdu_wb_t want, input logic chk_hi, input logic chk_lo);
		issue_op(op, a, b);
		@(negedge clk);
		check_idle();
		@(posedge clk);
		@(negedge clk);
		check_wb(want, chk_hi, chk_lo);
	endtask

	task automatic run_mult(input int bitn, input word_t a, input word_t b);
		logic [63:0] p;
		mdu_wb_t     want;
		p = mul_ref(a, b, bitn != OP_MULTU);
		if (bitn == OP_MUL)
			want = '{1'b0, 1'b0, 32'd0, p[31:0], 1'b0, 1'b0, 1'b1};
		else
			want = '{1'b1, 1'b1, p[63:32], p[31:0], 1'b0, 1'b0, 1'b0};
		run_op(op_of(bitn), a, b, want, bitn != OP_MUL, 1'b1);
	endtask

	task automatic read_hilo(input word_t hi_val, input word_t lo_val);
		run_op(op_of(OP_MFHI), '0, '0, '{1'b0, 1'b0, hi_val, 32'd0, 1'b1, 1'b0, 1'b0},
			1'b1, 1'b0);
		run_op(op_of(OP_MFLO), '0, '0, '{1'b0, 1'b0, 32'd0, lo_val, 1'b0, 1'b1, 1'b0},
			1'b0, 1'b1);
	endtask

	task automatic run_div(input int bitn, input word_t a, input word_t b);
		logic [63:0] r;
		int          n;
		r = div_ref(a, b, bitn == OP_DIV);
		issue_op(op_of(bitn), a, b);
		@(posedge clk);
		@(negedge clk);
		check_bits("stall_req_o", 32'(stall_req_o), 32'd1);
		check_bits("busy_o", 32'(busy_o), 32'd1);
		check_bits("div_busy_o", 32'(div_busy_o), 32'd1);
		n = 0;
		while (stall_req_o !== 1'b0 && n < DIV_TIMEOUT) begin
			check_idle();
			@(negedge clk);
			n++;
		end
		if (stall_req_o !== 1'b0) begin
			errors++;
			$display("divide of %h by %h did not finish within %0d cycles", a, b, DIV_TIMEOUT);
		end else begin
			check_wb('{1'b1, 1'b1, r[63:32], r[31:0], 1'b0, 1'b0, 1'b0}, 1'b1, 1'b1);
		end
	endtask

	task automatic test_reset();
		check_idle();
		check_bits("stall_req_o", 32'(stall_req_o), 32'd0);
		check_bits("busy_o", 32'(busy_o), 32'd0);
		check_bits("div_busy_o", 32'(div_busy_o), 32'd0);
		read_hilo('0, '0);
	endtask

	task automatic test_arith();
		word_t corner [4] = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000};
		word_t a;
		word_t b;
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				run_mult(OP_MULT, corner[i], corner[j]);
				run_mult(OP_MULTU, corner[i], corner[j]);
				run_mult(OP_MUL, corner[i], corner[j]);
				run_div(OP_DIV, corner[i], corner[j]);
				run_div(OP_DIVU, corner[i], corner[j]);
			end
		end
		for (int k = 0; k < 20; k++) begin
			a = $urandom;
			b = $urandom;
			run_mult(OP_MULT, a, b);
			run_mult(OP_MULTU, a, b);
			run_mult(OP_MUL, a, b);
			// spread the divisor magnitude
			b = b >> ($urandom % 32);
			run_div(k[0] ? OP_DIV : OP_DIVU, a, (k % 7 == 3) ? 32'd0 : b);
		end
	endtask

	// MTHI, MTLO, MFHI, MFLO on back-to-back cycles
	task automatic test_moves();
		word_t       h;
		word_t       l;
		logic [63:0] p;
		mdu_op_t     seq [4];
		mdu_wb_t     want [4];
		h = $urandom;
		l = $urandom;
		seq = '{op_of(OP_MTHI), op_of(OP_MTLO), op_of(OP_MFHI), op_of(OP_MFLO)};
		want[0] = '{1'b1, 1'b0, h, 32'd0, 1'b0, 1'b0, 1'b0};
		want[1] = '{1'b0, 1'b1, 32'd0, l, 1'b0, 1'b0, 1'b0};
		want[2] = '{1'b0, 1'b0, h, 32'd0, 1'b1, 1'b0, 1'b0};
		want[3] = '{1'b0, 1'b0, 32'd0, l, 1'b0, 1'b1, 1'b0};
		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			op_i   <= (k < 4) ? seq[k] : '0;
			opr1_i <= (k == 0) ? h : l;
			@(negedge clk);
			if (k >= 2)
				check_wb(want[k-2], want[k-2].hi_wen | want[k-2].mfhi,
					want[k-2].lo_wen | want[k-2].mflo);
		end
		h = $urandom;
		l = $urandom;
		p = mul_ref(h, l, 1'b1);
		run_mult(OP_MULT, h, l);
		read_hilo(p[63:32], p[31:0]);
	endtask

	// a MULT offered while stage 1 is stalled or flushed never shows up
	task automatic offer_blocked(input logic use_flush);
		@(posedge clk);
		op_i       <= op_of(OP_MULT);
		opr1_i     <= $urandom;
		opr2_i     <= $urandom;
		s1_stall_i <= ~use_flush;
		s1_flush_i <= use_flush;
		@(posedge clk);
		op_i       <= '0;
		s1_stall_i <= 1'b0;
		s1_flush_i <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_idle();
	endtask

	task automatic test_stall_flush();
		word_t h;
		word_t l;
		int    n;
		h = $urandom;
		l = $urandom;
		run_op(op_of(OP_MTHI), h, '0, '{1'b1, 1'b0, h, 32'd0, 1'b0, 1'b0, 1'b0}, 1'b1, 1'b0);
		run_op(op_of(OP_MTLO), l, '0, '{1'b0, 1'b1, 32'd0, l, 1'b0, 1'b0, 1'b0}, 1'b0, 1'b1);
		offer_blocked(1'b0);
		offer_blocked(1'b1);
		read_hilo(h, l);
		issue_op(op_of(OP_DIV), $urandom, 32'd7);
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_bits("stall_req_o", 32'(stall_req_o), 32'd1);
		@(posedge clk);
		s2_flush_i <= 1'b1;
		@(posedge clk);
		s2_flush_i <= 1'b0;
		n = 0;
		@(negedge clk);
		while (stall_req_o !== 1'b0 && n < 2) begin
			@(negedge clk);
			n++;
		end
		if (stall_req_o !== 1'b0) begin
			errors++;
			$display("stall_req_o still high two cycles after the stage 2 flush");
		end
		check_idle();
		read_hilo(h, l);
		// divider may still be finishing the aborted divide
		run_div(OP_DIVU, $urandom, $urandom);
	endtask

	initial begin
		clk        = 1'b0;
		rst_n_i    = 1'b0;
		op_i       = '0;
		opr1_i     = '0;
		opr2_i     = '0;
		s1_stall_i = 1'b0;
		s1_flush_i = 1'b0;
		s2_stall_i = 1'b0;
		s2_flush_i = 1'b0;
		errors     = 0;
		checks     = 0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		test_reset();
		test_arith();
		test_moves();
		test_stall_flush();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
mdu_pkg.sv
mdu_s1.sv
mdu_s2.sv
mdu_div.sv
mdu_hilo.sv
mdu_top.sv
tb_mdu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module tb_mdu -f tb.f -o tb_mdu_sim \
	&& ./obj_dir/tb_mdu_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }
